/* files.f */
source/ctrl_pkg.sv
source/position_if.sv
source/axil_write_slave.sv
source/position_regs.sv
source/status_readback.sv
source/engine_ctrl_top.sv
tb/tb_engine_ctrl.sv

/* source/axil_write_slave.sv */
`timescale 1ns/10ps

module axil_write_slave
(
   input  logic                                clk,
   input  logic                                rst,
   input  logic [ctrl_pkg::addr_width-1:0]     awaddr,
   input  logic                                awvalid,
   output logic                                awready,
   input  logic [ctrl_pkg::data_width-1:0]     wdata,
   input  logic                                wvalid,
   output logic                                wready,
   output logic                                bvalid,
   input  logic                                bready,
   output logic                                wr_valid,
   output logic [ctrl_pkg::reg_addr_width-1:0] wr_addr,
   output logic [ctrl_pkg::data_width-1:0]     wr_data
);

   ctrl_pkg::wr_state_e state;
   logic                aw_held;
   logic                w_held;
   logic                accepting;
   logic                aw_fire;
   logic                w_fire;
   logic                have_aw;
   logic                have_w;

   assign accepting = (state == ctrl_pkg::idle) || (state == ctrl_pkg::collect);
   assign awready   = accepting && !aw_held;
   assign wready    = accepting && !w_held;
   assign aw_fire   = awvalid && awready;
   assign w_fire    = wvalid && wready;
   assign have_aw   = aw_held || aw_fire;
   assign have_w    = w_held || w_fire;
   assign wr_valid  = (state == ctrl_pkg::strobe);
   assign bvalid    = (state == ctrl_pkg::respond);

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state   <= ctrl_pkg::idle;
         aw_held <= 1'b0;
         w_held  <= 1'b0;
      end
      else
      begin
         case (state)
            ctrl_pkg::idle, ctrl_pkg::collect:
            begin
               if (have_aw && have_w)
               begin
                  state   <= ctrl_pkg::strobe;
                  aw_held <= 1'b0;
                  w_held  <= 1'b0;
               end
               else
               begin
                  if (aw_fire || w_fire)
                     state <= ctrl_pkg::collect;   // Wait for the partner beat
                  aw_held <= have_aw;
                  w_held  <= have_w;
               end
            end
            ctrl_pkg::strobe: state <= ctrl_pkg::respond;
            default:
            begin
               if (bready)
                  state <= ctrl_pkg::idle;
            end
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (aw_fire)
         wr_addr <= awaddr[ctrl_pkg::addr_width-1:2];
      if (w_fire)
         wr_data <= wdata;
   end

   assert property (@(posedge clk) disable iff (rst) wr_valid |=> !wr_valid);
   assert property (@(posedge clk) disable iff (rst) bvalid && !bready |=> bvalid);

endmodule

/* source/ctrl_pkg.sv */
package ctrl_pkg;

   localparam int addr_width       = 16;
   localparam int reg_addr_width   = addr_width - 2;   // Word index, byte address bits 15:2
   localparam int data_width       = 32;
   localparam int side_width       = 32;               // Eight squares of four bits
   localparam int board_ranks      = 8;
   localparam int board_width      = side_width * board_ranks;
   localparam int move_index_width = 8;
   localparam int half_move_width  = 8;
   localparam int eval_width       = 24;
   localparam int uci_width        = 16;

   // Control word bits written by the host
   localparam int ctrl_new_board_bit   = 0;
   localparam int ctrl_clear_moves_bit = 1;
   localparam int ctrl_random_bit      = 30;
   localparam int ctrl_soft_reset_bit  = 31;

   typedef enum logic [reg_addr_width-1:0]
   {
      ctrl         = 0,
      move_index   = 1,
      side         = 2,
      half_move    = 3,
      capture      = 4,
      board0       = 8,     // Rank words 8 to 15
      mg_flags     = 132,
      mg_side      = 133,
      mg_eval      = 134,
      mg_count     = 135,
      root_eval    = 136,
      mg_half_move = 138,
      mg_uci       = 139
   } reg_addr_e;

   typedef enum logic [1:0]
   {
      idle,
      collect,   // One beat held
      strobe,
      respond
   } wr_state_e;

endpackage

/* source/engine_ctrl_top.sv */
`timescale 1ns/10ps

module engine_ctrl_top
(
   input  logic                                   clk,
   input  logic                                   rst,
   input  logic [ctrl_pkg::addr_width-1:0]        awaddr,
   input  logic                                   awvalid,
   output logic                                   awready,
   input  logic [ctrl_pkg::data_width-1:0]        wdata,
   input  logic                                   wvalid,
   output logic                                   wready,
   output logic                                   bvalid,
   input  logic                                   bready,
   input  logic [ctrl_pkg::addr_width-1:0]        araddr,
   input  logic                                   arvalid,
   output logic                                   arready,
   output logic [ctrl_pkg::data_width-1:0]        rdata,
   output logic                                   rvalid,
   input  logic                                   rready,
   input  logic                                   mg_idle,
   input  logic                                   mg_moves_ready,
   input  logic                                   mg_move_ready,
   input  logic                                   mg_capture,
   input  logic                                   mg_white_in_check,
   input  logic                                   mg_black_in_check,
   input  logic                                   mg_thrice_rep,
   input  logic                                   mg_fifty_move,
   input  logic                                   mg_insufficient_material,
   input  logic                                   mg_white_to_move,
   input  logic [3:0]                             mg_castle_mask,
   input  logic [3:0]                             mg_en_passant_col,
   input  logic signed [ctrl_pkg::eval_width-1:0] mg_eval,
   input  logic [ctrl_pkg::move_index_width-1:0]  mg_move_count,
   input  logic [ctrl_pkg::half_move_width-1:0]   mg_half_move,
   input  logic [ctrl_pkg::uci_width-1:0]         mg_uci,
   input  logic signed [ctrl_pkg::eval_width-1:0] root_eval,
   input  logic                                   root_mate,
   input  logic                                   root_stalemate,
   input  logic                                   root_check,
   output logic                                   new_board_valid,
   output logic                                   clear_moves,
   output logic                                   capture_moves,
   output logic                                   use_random_bit,
   output logic                                   soft_reset,
   output logic [ctrl_pkg::move_index_width-1:0]  move_index,
   output logic                                   white_to_move,
   output logic [3:0]                             castle_mask,
   output logic [3:0]                             en_passant_col,
   output logic [ctrl_pkg::half_move_width-1:0]   half_move,
   output logic [ctrl_pkg::board_width-1:0]       board
);

   logic                                wr_valid;
   logic [ctrl_pkg::reg_addr_width-1:0] wr_addr;
   logic [ctrl_pkg::data_width-1:0]     wr_data;

   position_if regs_if ();

   axil_write_slave u_write
   (
      .clk      (clk),
      .rst      (rst),
      .awaddr   (awaddr),
      .awvalid  (awvalid),
      .awready  (awready),
      .wdata    (wdata),
      .wvalid   (wvalid),
      .wready   (wready),
      .bvalid   (bvalid),
      .bready   (bready),
      .wr_valid (wr_valid),
      .wr_addr  (wr_addr),
      .wr_data  (wr_data)
   );

   position_regs u_regs
   (
      .clk      (clk),
      .rst      (rst),
      .wr_valid (wr_valid),
      .wr_addr  (wr_addr),
      .wr_data  (wr_data),
      .regs     (regs_if.bank)
   );

   status_readback u_read
   (
      .clk                      (clk),
      .rst                      (rst),
      .araddr                   (araddr),
      .arvalid                  (arvalid),
      .arready                  (arready),
      .rvalid                   (rvalid),
      .rdata                    (rdata),
      .rready                   (rready),
      .regs                     (regs_if.mux),
      .mg_idle                  (mg_idle),
      .mg_moves_ready           (mg_moves_ready),
      .mg_move_ready            (mg_move_ready),
      .mg_capture               (mg_capture),
      .mg_white_in_check        (mg_white_in_check),
      .mg_black_in_check        (mg_black_in_check),
      .mg_thrice_rep            (mg_thrice_rep),
      .mg_fifty_move            (mg_fifty_move),
      .mg_insufficient_material (mg_insufficient_material),
      .mg_white_to_move         (mg_white_to_move),
      .mg_castle_mask           (mg_castle_mask),
      .mg_en_passant_col        (mg_en_passant_col),
      .mg_eval                  (mg_eval),
      .mg_move_count            (mg_move_count),
      .mg_half_move             (mg_half_move),
      .mg_uci                   (mg_uci),
      .root_eval                (root_eval),
      .root_mate                (root_mate),
      .root_stalemate           (root_stalemate),
      .root_check               (root_check)
   );

   // Position toward the move generator
   assign new_board_valid = regs_if.new_board_valid;
   assign clear_moves     = regs_if.clear_moves;
   assign capture_moves   = regs_if.capture_moves;
   assign use_random_bit  = regs_if.use_random_bit;
   assign soft_reset      = regs_if.soft_reset;
   assign move_index      = regs_if.move_index;
   assign white_to_move   = regs_if.white_to_move;
   assign castle_mask     = regs_if.castle_mask;
   assign en_passant_col  = regs_if.en_passant_col;
   assign half_move       = regs_if.half_move;
   assign board           = regs_if.board;

endmodule

/* source/position_if.sv */
`timescale 1ns/10ps

interface position_if;

   logic                                    new_board_valid;
   logic                                    clear_moves;
   logic                                    capture_moves;
   logic                                    use_random_bit;
   logic                                    soft_reset;
   logic [ctrl_pkg::move_index_width-1:0]   move_index;
   logic                                    white_to_move;
   logic [3:0]                              castle_mask;
   logic [3:0]                              en_passant_col;
   logic [ctrl_pkg::half_move_width-1:0]    half_move;
   logic [ctrl_pkg::board_width-1:0]        board;

   modport bank
   (
      output new_board_valid, clear_moves, capture_moves, use_random_bit, soft_reset,
      output move_index, white_to_move, castle_mask, en_passant_col, half_move, board
   );

   modport mux
   (
      input new_board_valid, clear_moves, capture_moves, use_random_bit, soft_reset,
      input move_index, white_to_move, castle_mask, en_passant_col, half_move, board
   );

endinterface

/* source/position_regs.sv */
`timescale 1ns/10ps

module position_regs
(
   input  logic                                clk,
   input  logic                                rst,
   input  logic                                wr_valid,
   input  logic [ctrl_pkg::reg_addr_width-1:0] wr_addr,
   input  logic [ctrl_pkg::data_width-1:0]     wr_data,
   position_if.bank                            regs
);

   logic [ctrl_pkg::reg_addr_width-1:0]     rank_offset;
   logic [$clog2(ctrl_pkg::board_ranks)-1:0] rank;
   logic                                    in_board;

   assign rank_offset = wr_addr - ctrl_pkg::board0;
   assign in_board    = rank_offset < ctrl_pkg::board_ranks;
   assign rank        = rank_offset[$clog2(ctrl_pkg::board_ranks)-1:0];

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         regs.new_board_valid <= 1'b0;
         regs.clear_moves     <= 1'b0;
         regs.capture_moves   <= 1'b0;
         regs.use_random_bit  <= 1'b0;
         regs.soft_reset      <= 1'b0;
         regs.move_index      <= '0;
         regs.white_to_move   <= 1'b0;
         regs.castle_mask     <= '0;
         regs.en_passant_col  <= '0;
         regs.half_move       <= '0;
         regs.board           <= '0;
      end
      else if (wr_valid)
      begin
         if (in_board)
            regs.board[rank*ctrl_pkg::side_width +: ctrl_pkg::side_width] <=
               wr_data[ctrl_pkg::side_width-1:0];
         else
         begin
            case (wr_addr)
               ctrl_pkg::ctrl:
               begin
                  regs.new_board_valid <= wr_data[ctrl_pkg::ctrl_new_board_bit];
                  regs.clear_moves     <= wr_data[ctrl_pkg::ctrl_clear_moves_bit];
                  regs.use_random_bit  <= wr_data[ctrl_pkg::ctrl_random_bit];
                  regs.soft_reset      <= wr_data[ctrl_pkg::ctrl_soft_reset_bit];
               end
               ctrl_pkg::move_index:
                  regs.move_index <= wr_data[ctrl_pkg::move_index_width-1:0];
               ctrl_pkg::side:   // Side to move, castle rights, ep column
                  {regs.white_to_move, regs.castle_mask, regs.en_passant_col} <= wr_data[8:0];
               ctrl_pkg::half_move:
                  regs.half_move <= wr_data[ctrl_pkg::half_move_width-1:0];
               ctrl_pkg::capture:
                  regs.capture_moves <= wr_data[0];
               default:
               begin
               end
            endcase
         end
      end
   end

   assert property (@(posedge clk) disable iff (rst)
      !wr_valid |=> $stable({regs.new_board_valid, regs.clear_moves, regs.capture_moves,
                             regs.use_random_bit, regs.soft_reset, regs.move_index,
                             regs.white_to_move, regs.castle_mask, regs.en_passant_col,
                             regs.half_move, regs.board}));

endmodule

/* source/status_readback.sv */
`timescale 1ns/10ps

module status_readback
(
   input  logic                                   clk,
   input  logic                                   rst,
   input  logic [ctrl_pkg::addr_width-1:0]        araddr,
   input  logic                                   arvalid,
   output logic                                   arready,
   output logic                                   rvalid,
   output logic [ctrl_pkg::data_width-1:0]        rdata,
   input  logic                                   rready,
   position_if.mux                                regs,
   input  logic                                   mg_idle,
   input  logic                                   mg_moves_ready,
   input  logic                                   mg_move_ready,
   input  logic                                   mg_capture,
   input  logic                                   mg_white_in_check,
   input  logic                                   mg_black_in_check,
   input  logic                                   mg_thrice_rep,
   input  logic                                   mg_fifty_move,
   input  logic                                   mg_insufficient_material,
   input  logic                                   mg_white_to_move,
   input  logic [3:0]                             mg_castle_mask,
   input  logic [3:0]                             mg_en_passant_col,
   input  logic signed [ctrl_pkg::eval_width-1:0] mg_eval,
   input  logic [ctrl_pkg::move_index_width-1:0]  mg_move_count,
   input  logic [ctrl_pkg::half_move_width-1:0]   mg_half_move,
   input  logic [ctrl_pkg::uci_width-1:0]         mg_uci,
   input  logic signed [ctrl_pkg::eval_width-1:0] root_eval,
   input  logic                                   root_mate,
   input  logic                                   root_stalemate,
   input  logic                                   root_check
);

   localparam int ext_width = ctrl_pkg::data_width - ctrl_pkg::eval_width;

   logic [ctrl_pkg::reg_addr_width-1:0]      rd_addr;
   logic [ctrl_pkg::reg_addr_width-1:0]      rd_offset;
   logic [$clog2(ctrl_pkg::board_ranks)-1:0] rd_rank;
   logic [ctrl_pkg::data_width-1:0]          rd_word;

   assign rd_addr   = araddr[ctrl_pkg::addr_width-1:2];
   assign rd_offset = rd_addr - ctrl_pkg::board0;
   assign rd_rank   = rd_offset[$clog2(ctrl_pkg::board_ranks)-1:0];
   assign arready   = !rvalid;   // One read in flight

   always_comb
   begin
      rd_word = '0;
      if (rd_offset < ctrl_pkg::board_ranks)
         rd_word[ctrl_pkg::side_width-1:0] =
            regs.board[rd_rank*ctrl_pkg::side_width +: ctrl_pkg::side_width];
      else
      begin
         case (rd_addr)
            ctrl_pkg::ctrl:
            begin
               rd_word[ctrl_pkg::ctrl_new_board_bit]   = regs.new_board_valid;
               rd_word[ctrl_pkg::ctrl_clear_moves_bit] = regs.clear_moves;
               rd_word[2]                              = mg_moves_ready;
               rd_word[3]                              = mg_move_ready;
               rd_word[4]                              = root_stalemate;
               rd_word[5]                              = root_mate;
               rd_word[7]                              = mg_idle;
               rd_word[10]                             = root_check;
               rd_word[ctrl_pkg::ctrl_random_bit]      = regs.use_random_bit;
               rd_word[ctrl_pkg::ctrl_soft_reset_bit]  = regs.soft_reset;
            end
            ctrl_pkg::move_index:
               rd_word[ctrl_pkg::move_index_width-1:0] = regs.move_index;
            ctrl_pkg::side:
               rd_word[8:0] = {regs.white_to_move, regs.castle_mask, regs.en_passant_col};
            ctrl_pkg::half_move:
               rd_word[ctrl_pkg::half_move_width-1:0] = regs.half_move;
            ctrl_pkg::capture:
               rd_word[0] = regs.capture_moves;
            ctrl_pkg::mg_flags:
               rd_word[5:0] = {mg_insufficient_material, mg_fifty_move, mg_thrice_rep,
                               mg_black_in_check, mg_white_in_check, mg_capture};
            ctrl_pkg::mg_side:
               rd_word[8:0] = {mg_white_to_move, mg_castle_mask, mg_en_passant_col};
            ctrl_pkg::mg_eval:
               rd_word = {{ext_width{mg_eval[ctrl_pkg::eval_width-1]}}, mg_eval};
            ctrl_pkg::mg_count:
               rd_word[ctrl_pkg::move_index_width-1:0] = mg_move_count;
            ctrl_pkg::root_eval:
               rd_word = {{ext_width{root_eval[ctrl_pkg::eval_width-1]}}, root_eval};
            ctrl_pkg::mg_half_move:
               rd_word[ctrl_pkg::half_move_width-1:0] = mg_half_move;
            ctrl_pkg::mg_uci:   // Zero bit between the packed fields
               rd_word[19:0] = {mg_uci[15:12], 1'b0, mg_uci[11:9], 1'b0, mg_uci[8:6],
                                1'b0, mg_uci[5:3], 1'b0, mg_uci[2:0]};
            default:
               rd_word = '0;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
         rvalid <= 1'b0;
      else if (arvalid && arready)
         rvalid <= 1'b1;
      else if (rready)
         rvalid <= 1'b0;
   end

   always_ff @(posedge clk)
   begin
      if (arvalid && arready)
         rdata <= rd_word;   // Sampled at the ar handshake
   end

   assert property (@(posedge clk) disable iff (rst) rvalid && !rready |=> $stable(rdata));

endmodule

/* tb/tb_engine_ctrl.sv */
`timescale 1ns/10ps

module tb_engine_ctrl;

   logic          clk;
   logic          rst;
   logic [15:0]   awaddr;
   logic          awvalid;
   logic          awready;
   logic [31:0]   wdata;
   logic          wvalid;
   logic          wready;
   logic          bvalid;
   logic          bready;
   logic [15:0]   araddr;
   logic          arvalid;
   logic          arready;
   logic [31:0]   rdata;
   logic          rvalid;
   logic          rready;
   logic          mg_idle;
   logic          mg_moves_ready;
   logic          mg_move_ready;
   logic          mg_capture;
   logic          mg_white_in_check;
   logic          mg_black_in_check;
   logic          mg_thrice_rep;
   logic          mg_fifty_move;
   logic          mg_insufficient_material;
   logic          mg_white_to_move;
   logic [3:0]    mg_castle_mask;
   logic [3:0]    mg_en_passant_col;
   logic [23:0]   mg_eval;
   logic [7:0]    mg_move_count;
   logic [7:0]    mg_half_move;
   logic [15:0]   mg_uci;
   logic [23:0]   root_eval;
   logic          root_mate;
   logic          root_stalemate;
   logic          root_check;
   logic          new_board_valid;
   logic          clear_moves;
   logic          capture_moves;
   logic          use_random_bit;
   logic          soft_reset;
   logic [7:0]    move_index;
   logic          white_to_move;
   logic [3:0]    castle_mask;
   logic [3:0]    en_passant_col;
   logic [7:0]    half_move;
   logic [255:0]  board;

   int            seed;
   int            checks;
   int            errors;
   logic [31:0]   rd;
   logic [31:0]   data;
   logic [31:0]   ctrl_data;
   logic [255:0]  board_exp;
   logic [285:0]  outputs_now;   // Every register output toward the move generator

   engine_ctrl_top dut (.*);

   assign outputs_now = {new_board_valid, clear_moves, capture_moves, use_random_bit,
                         soft_reset, move_index, white_to_move, castle_mask, en_passant_col,
                         half_move, board};

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic void expect_value(input string name, input logic [511:0] expected,
                                        input logic [511:0] actual);
      checks++;
      assert (actual === expected)
      else
      begin
         errors++;
         $display("CHECK FAILED at %0t: %s expected %0h actual %0h",
                  $time, name, expected, actual);
      end
   endfunction

   function automatic void report_timeout(input string what);
      errors++;
      $display("Timeout at %0t while waiting for %s", $time, what);
   endfunction

   // Host bits plus live move generator status
   function automatic logic [31:0] ctrl_readback(input logic [31:0] written);
      logic [31:0] word;
      word     = '0;
      word[0]  = written[0];
      word[1]  = written[1];
      word[2]  = mg_moves_ready;
      word[3]  = mg_move_ready;
      word[4]  = root_stalemate;
      word[5]  = root_mate;
      word[7]  = mg_idle;
      word[10] = root_check;
      word[30] = written[30];
      word[31] = written[31];
      return word;
   endfunction

   // Order 0 sends both beats together, 1 address first, 2 data first
   task automatic bus_write(input int word, input logic [31:0] value, input int order);
      int           t;
      int           stall;
      logic         aw_fire;
      logic         w_fire;
      logic [285:0] outs_before;
      logic [285:0] outs_after;
      @(negedge clk);
      outs_before = outputs_now;
      awaddr  = 16'(word * 4);
      wdata   = value;
      awvalid = (order != 2);
      wvalid  = (order != 1);
      t = 0;
      while (awvalid || wvalid)
      begin
         aw_fire = awvalid && awready;   // Transfers on the coming rising edge
         w_fire  = wvalid && wready;
         @(negedge clk);
         if (aw_fire)
         begin
            awvalid = 1'b0;
            if (order == 1)
               wvalid = 1'b1;
         end
         if (w_fire)
         begin
            wvalid = 1'b0;
            if (order == 2)
               awvalid = 1'b1;
         end
         t++;
         if (t > 50)
         begin
            report_timeout("awready or wready");
            awvalid = 1'b0;
            wvalid  = 1'b0;
         end
      end
      // Update lands at the end of the strobe cycle
      expect_value("outputs before update", outs_before, outputs_now);
      @(negedge clk);
      outs_after = outputs_now;
      t = 0;
      while (!bvalid && t < 50)
      begin
         @(negedge clk);
         t++;
      end
      if (!bvalid)
         report_timeout("bvalid");
      stall = 1 + $unsigned($random(seed)) % 3;
      repeat (stall) @(negedge clk);   // Response held off
      bready = 1'b1;
      @(negedge clk);
      bready = 1'b0;
      expect_value("outputs after update", outs_after, outputs_now);
   endtask

   task automatic bus_read(input int word, output logic [31:0] value);
      int t;
      int stall;
      @(negedge clk);
      araddr  = 16'(word * 4);
      arvalid = 1'b1;
      t = 0;
      while (!arready && t < 50)
      begin
         @(negedge clk);
         t++;
      end
      if (!arready)
         report_timeout("arready");
      @(negedge clk);
      arvalid = 1'b0;
      t = 0;
      while (!rvalid && t < 50)
      begin
         @(negedge clk);
         t++;
      end
      if (!rvalid)
         report_timeout("rvalid");
      stall = 1 + $unsigned($random(seed)) % 3;
      repeat (stall) @(negedge clk);
      value  = rdata;
      rready = 1'b1;
      @(negedge clk);
      rready = 1'b0;
   endtask

   task automatic drive_mg_inputs(input int round);
      logic [31:0] bits;
      @(negedge clk);
      bits = $random(seed);
      {mg_idle, mg_moves_ready, mg_move_ready, mg_capture, mg_white_in_check,
       mg_black_in_check, mg_thrice_rep, mg_fifty_move, mg_insufficient_material,
       mg_white_to_move, root_mate, root_stalemate, root_check} = bits[12:0];
      bits          = $random(seed);
      mg_eval       = bits[23:0];
      mg_move_count = bits[31:24];
      bits          = $random(seed);
      root_eval     = bits[23:0];
      mg_half_move  = bits[31:24];
      bits              = $random(seed);
      mg_uci            = bits[15:0];
      mg_castle_mask    = bits[19:16];
      mg_en_passant_col = bits[23:20];
      mg_eval[23]   = round[0];   // Both signs over the rounds
      root_eval[23] = ~round[0];
   endtask

   initial
   begin
      seed    = 59650;
      checks  = 0;
      errors  = 0;
      rst     = 1'b1;
      awaddr  = '0;
      awvalid = 1'b0;
      wdata   = '0;
      wvalid  = 1'b0;
      bready  = 1'b0;
      araddr  = '0;
      arvalid = 1'b0;
      rready  = 1'b0;
      {mg_idle, mg_moves_ready, mg_move_ready, mg_capture, mg_white_in_check,
       mg_black_in_check, mg_thrice_rep, mg_fifty_move, mg_insufficient_material,
       mg_white_to_move, root_mate, root_stalemate, root_check} = '0;
      mg_castle_mask    = '0;
      mg_en_passant_col = '0;
      mg_eval           = '0;
      mg_move_count     = '0;
      mg_half_move      = '0;
      mg_uci            = '0;
      root_eval         = '0;
      repeat (10) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      @(negedge clk);

      expect_value("register outputs", '0, {new_board_valid, clear_moves, capture_moves,
                   use_random_bit, soft_reset, move_index, white_to_move, castle_mask,
                   en_passant_col, half_move});
      expect_value("board", '0, board);
      expect_value("bvalid", 1'b0, bvalid);
      expect_value("rvalid", 1'b0, rvalid);
      expect_value("awready", 1'b1, awready);
      expect_value("wready", 1'b1, wready);
      expect_value("arready", 1'b1, arready);

      for (int pass = 0; pass < 2; pass++)
      begin
         ctrl_data = (pass == 0) ? $random(seed) : ~ctrl_data;   // Each bit both ways
         bus_write(ctrl_pkg::ctrl, ctrl_data, pass);
         expect_value("new_board_valid", ctrl_data[0], new_board_valid);
         expect_value("clear_moves", ctrl_data[1], clear_moves);
         expect_value("use_random_bit", ctrl_data[30], use_random_bit);
         expect_value("soft_reset", ctrl_data[31], soft_reset);
         bus_read(ctrl_pkg::ctrl, rd);
         expect_value("rdata ctrl", ctrl_readback(ctrl_data), rd);
      end

      data = $random(seed);
      bus_write(ctrl_pkg::move_index, data, 1);
      expect_value("move_index", data[7:0], move_index);
      bus_read(ctrl_pkg::move_index, rd);
      expect_value("rdata move_index", {24'b0, data[7:0]}, rd);
      data = $random(seed);
      bus_write(ctrl_pkg::side, data, 2);
      expect_value("white_to_move", data[8], white_to_move);
      expect_value("castle_mask", data[7:4], castle_mask);
      expect_value("en_passant_col", data[3:0], en_passant_col);
      bus_read(ctrl_pkg::side, rd);
      expect_value("rdata side", {23'b0, data[8:0]}, rd);
      data = $random(seed);
      bus_write(ctrl_pkg::half_move, data, 0);
      expect_value("half_move", data[7:0], half_move);
      bus_read(ctrl_pkg::half_move, rd);
      expect_value("rdata half_move", {24'b0, data[7:0]}, rd);
      data = 32'h1;
      bus_write(ctrl_pkg::capture, data, 1);
      expect_value("capture_moves", 1'b1, capture_moves);
      bus_read(ctrl_pkg::capture, rd);
      expect_value("rdata capture", 32'h1, rd);

      board_exp = '0;
      for (int r = 0; r < 8; r++)
      begin
         data = $random(seed);
         board_exp[r*32 +: 32] = data;
         bus_write(ctrl_pkg::board0 + r, data, r % 3);
         expect_value("board rank", data, board[r*32 +: 32]);
         bus_read(ctrl_pkg::board0 + r, rd);
         expect_value("rdata board rank", data, rd);
      end
      expect_value("board", board_exp, board);   // No rank overwritten by another

      for (int round = 0; round < 3; round++)
      begin
         drive_mg_inputs(round);
         bus_read(ctrl_pkg::mg_flags, rd);
         expect_value("rdata mg_flags", {26'b0, mg_insufficient_material, mg_fifty_move,
                      mg_thrice_rep, mg_black_in_check, mg_white_in_check, mg_capture}, rd);
         bus_read(ctrl_pkg::mg_side, rd);
         expect_value("rdata mg_side",
                      {23'b0, mg_white_to_move, mg_castle_mask, mg_en_passant_col}, rd);
         bus_read(ctrl_pkg::mg_eval, rd);
         expect_value("rdata mg_eval", {{8{mg_eval[23]}}, mg_eval}, rd);
         bus_read(ctrl_pkg::mg_count, rd);
         expect_value("rdata mg_count", {24'b0, mg_move_count}, rd);
         bus_read(ctrl_pkg::root_eval, rd);
         expect_value("rdata root_eval", {{8{root_eval[23]}}, root_eval}, rd);
         bus_read(ctrl_pkg::mg_half_move, rd);
         expect_value("rdata mg_half_move", {24'b0, mg_half_move}, rd);
         bus_read(ctrl_pkg::mg_uci, rd);
         expect_value("rdata mg_uci", {12'b0, mg_uci[15:12], 1'b0, mg_uci[11:9], 1'b0,
                      mg_uci[8:6], 1'b0, mg_uci[5:3], 1'b0, mg_uci[2:0]}, rd);
         bus_read(ctrl_pkg::ctrl, rd);
         expect_value("rdata ctrl", ctrl_readback(ctrl_data), rd);
         bus_read(137, rd);   // Hole between root_eval and mg_half_move
         expect_value("rdata unmapped", '0, rd);
         bus_read(5 + round, rd);
         expect_value("rdata unmapped", '0, rd);
      end

      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

   assert property (@(posedge clk) disable iff (rst) bvalid && !bready |=> bvalid)
   else
   begin
      errors++;
      $display("bvalid dropped before bready at %0t", $time);
   end

   assert property (@(posedge clk) disable iff (rst) bvalid |-> !awready && !wready)
   else
   begin
      errors++;
      $display("Write channel accepted a beat while a response was pending at %0t", $time);
   end

   assert property (@(posedge clk) disable iff (rst)
      rvalid && !rready |=> rvalid && $stable(rdata))
   else
   begin
      errors++;
      $display("Read response changed before rready at %0t", $time);
   end

   assert property (@(posedge clk) disable iff (rst) rvalid |-> !arready)
   else
   begin
      errors++;
      $display("arready high while a read response was pending at %0t", $time);
   end

endmodule
